// File: commit_settings.svh
`ifndef COMMIT_SETTINGS_SVH
`define COMMIT_SETTINGS_SVH

// address width of pc, mem_addr and badv
`define ADDR_W 32

// LoongArch exception codes
`define ECODE_INT  6'h00
`define ECODE_PIL  6'h01
`define ECODE_PIS  6'h02
`define ECODE_PIF  6'h03
`define ECODE_PME  6'h04
`define ECODE_PPI  6'h07
`define ECODE_ADEF 6'h08
`define ECODE_ADEM 6'h08
`define ECODE_ALE  6'h09
`define ECODE_SYS  6'h0b
`define ECODE_BRK  6'h0c
`define ECODE_INE  6'h0d
`define ECODE_IPE  6'h0e
`define ECODE_TLBR 6'h3f

`define ESUBCODE_ADEF 9'h000
`define ESUBCODE_ADEM 9'h001

// cause-bit positions in excp_num
`define CAUSE_ADEF     1
`define CAUSE_TLBR_F   2
`define CAUSE_FETCH_HI 4
`define CAUSE_MEM_LO   9
`define CAUSE_TLBR_M   11

`endif

// File: commit_pkg.sv
`include "commit_settings.svh"

`default_nettype none

package commit_pkg;

    typedef enum logic [4:0] {
        OP_ALU,
        OP_LL,
        OP_SC,
        OP_CSRWR,
        OP_CSRRD,
        OP_SYSCALL,
        OP_BREAK,
        OP_ERTN,
        OP_IDLE,
        OP_TLBSRCH,
        OP_BRANCH
    } op_e;

    // one lane as it reaches writeback
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic [`ADDR_W-1:0] pc;
        logic [15:0]       excp_num;
        logic [`ADDR_W-1:0] mem_addr;
        logic [4:0]        rd;
        logic              rd_we;
        logic [31:0]       rd_data;
        logic              is_priv;
        // nothing may commit behind this lane
        logic              ends_group;
    } wb_lane_t;

    // fields handed to the CSR block on an exception
    typedef struct packed {
        logic [5:0]         ecode;
        logic               va_error;
        logic [`ADDR_W-1:0] badv;
        logic [8:0]         esubcode;
        logic               tlbrefill;
        logic               excp_tlb;
        logic [18:0]        tlb_vppn;
    } excp_report_t;

    typedef struct packed {
        logic we;
        logic value;
    } llbit_t;

endpackage

`default_nettype wire

// File: lane_pair_if.sv
`default_nettype none

// two issue lanes moving together between stages
interface lane_pair_if
    import commit_pkg::*;
();

    wb_lane_t lane [0:1];

    // producer side
    modport src (
        output lane
    );

    // consumer side
    modport dst (
        input lane
    );

endinterface

`default_nettype wire

// File: lane_decode.sv
`include "commit_settings.svh"

`default_nettype none

module lane_decode
    import commit_pkg::*;
(
    input  wire logic               lane0_valid_i,
    input  op_e                     lane0_op_i,
    input  wire logic [`ADDR_W-1:0] lane0_pc_i,
    input  wire logic [15:0]        lane0_excp_num_i,
    input  wire logic [`ADDR_W-1:0] lane0_mem_addr_i,
    input  wire logic [4:0]         lane0_rd_i,
    input  wire logic               lane0_rd_we_i,
    input  wire logic [31:0]        lane0_rd_data_i,
    input  wire logic               lane1_valid_i,
    input  op_e                     lane1_op_i,
    input  wire logic [`ADDR_W-1:0] lane1_pc_i,
    input  wire logic [15:0]        lane1_excp_num_i,
    input  wire logic [`ADDR_W-1:0] lane1_mem_addr_i,
    input  wire logic [4:0]         lane1_rd_i,
    input  wire logic               lane1_rd_we_i,
    input  wire logic [31:0]        lane1_rd_data_i,
    lane_pair_if.src                dec_o
);

    wb_lane_t rec [0:1];

    // privileged classes hold off issue until they commit
    function automatic logic op_is_priv(input op_e op);
        return op inside {OP_CSRWR, OP_CSRRD, OP_SYSCALL, OP_BREAK,
                          OP_ERTN, OP_IDLE, OP_TLBSRCH};
    endfunction

    function automatic logic op_ends_group(input op_e op);
        return op inside {OP_ERTN, OP_SYSCALL, OP_BREAK, OP_IDLE};
    endfunction

    always_comb begin
        rec[0] = '{lane0_valid_i, lane0_op_i, lane0_pc_i, lane0_excp_num_i,
                   lane0_mem_addr_i, lane0_rd_i, lane0_rd_we_i, lane0_rd_data_i,
                   1'b0, 1'b0};
        rec[1] = '{lane1_valid_i, lane1_op_i, lane1_pc_i, lane1_excp_num_i,
                   lane1_mem_addr_i, lane1_rd_i, lane1_rd_we_i, lane1_rd_data_i,
                   1'b0, 1'b0};
        // class flags from the op
        for (int i = 0; i < 2; i++) begin
            rec[i].is_priv = op_is_priv(rec[i].op);
            rec[i].ends_group = op_ends_group(rec[i].op);
        end
    end

    assign dec_o.lane[0] = rec[0];
    assign dec_o.lane[1] = rec[1];

endmodule

`default_nettype wire

// File: wb_pipe_reg.sv
`default_nettype none

// writeback register for the lane pair
// advances every cycle and stall requests never hold it
module wb_pipe_reg (
    input  wire logic       clk,
    input  wire logic       rst,
    lane_pair_if.dst        dec_i,
    input  wire logic [1:0] lane_kill_i,
    lane_pair_if.src        wb_o
);

    genvar g;

    generate
        for (g = 0; g < 2; g++) begin : g_lane
            // payload follows the incoming lane
            always_ff @(posedge clk) begin
                wb_o.lane[g].op         <= dec_i.lane[g].op;
                wb_o.lane[g].pc         <= dec_i.lane[g].pc;
                wb_o.lane[g].excp_num   <= dec_i.lane[g].excp_num;
                wb_o.lane[g].mem_addr   <= dec_i.lane[g].mem_addr;
                wb_o.lane[g].rd         <= dec_i.lane[g].rd;
                wb_o.lane[g].rd_we      <= dec_i.lane[g].rd_we;
                wb_o.lane[g].rd_data    <= dec_i.lane[g].rd_data;
                wb_o.lane[g].is_priv    <= dec_i.lane[g].is_priv;
                wb_o.lane[g].ends_group <= dec_i.lane[g].ends_group;
            end

            // killed lanes enter as bubbles
            always_ff @(posedge clk) begin
                if (rst) begin
                    wb_o.lane[g].valid <= 1'b0;
                end else begin
                    wb_o.lane[g].valid <= dec_i.lane[g].valid & ~lane_kill_i[g];
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

// File: excp_encoder.sv
`include "commit_settings.svh"

`default_nettype none

module excp_encoder
    import commit_pkg::*;
(
    input  wb_lane_t                lane0_i,
    input  wb_lane_t                lane1_i,
    output logic                    excp_o,
    output excp_report_t            report_o,
    output logic [`ADDR_W-1:0]      excp_pc_o
);

    logic       l0_hit;
    logic       l1_hit;
    wb_lane_t   sel;
    logic [3:0] cause_idx;
    logic       fetch_side;
    logic       mem_side;

    // lane 0 always wins
    assign l0_hit = lane0_i.valid && (lane0_i.excp_num != '0);
    assign l1_hit = lane1_i.valid && (lane1_i.excp_num != '0);
    assign excp_o = l0_hit | l1_hit;
    assign sel = (!l0_hit && l1_hit) ? lane1_i : lane0_i;
    assign excp_pc_o = sel.pc;

    // lowest set cause bit
    always_comb begin
        cause_idx = '0;
        for (int i = 15; i >= 0; i--) begin
            if (sel.excp_num[i]) begin
                cause_idx = i[3:0];
            end
        end
    end

    assign fetch_side = (cause_idx >= `CAUSE_ADEF) && (cause_idx <= `CAUSE_FETCH_HI);
    assign mem_side = (cause_idx >= `CAUSE_MEM_LO);

    always_comb begin
        report_o = '0;
        if (excp_o) begin
            case (cause_idx)
                4'd0:  report_o.ecode = `ECODE_INT;
                4'd1:  report_o.ecode = `ECODE_ADEF;
                4'd2:  report_o.ecode = `ECODE_TLBR;
                4'd3:  report_o.ecode = `ECODE_PIF;
                4'd4:  report_o.ecode = `ECODE_PPI;
                4'd5:  report_o.ecode = `ECODE_SYS;
                4'd6:  report_o.ecode = `ECODE_BRK;
                4'd7:  report_o.ecode = `ECODE_INE;
                4'd8:  report_o.ecode = `ECODE_IPE;
                4'd9:  report_o.ecode = `ECODE_ALE;
                4'd10: report_o.ecode = `ECODE_ADEM;
                4'd11: report_o.ecode = `ECODE_TLBR;
                4'd12: report_o.ecode = `ECODE_PME;
                4'd13: report_o.ecode = `ECODE_PPI;
                4'd14: report_o.ecode = `ECODE_PIS;
                default: report_o.ecode = `ECODE_PIL;
            endcase
            if (cause_idx == `CAUSE_ADEF) report_o.esubcode = `ESUBCODE_ADEF;
            if (cause_idx == 4'd10) report_o.esubcode = `ESUBCODE_ADEM;
            // bad address from pc or from the data access
            if (fetch_side) begin
                report_o.va_error = 1'b1;
                report_o.badv = sel.pc;
            end else if (mem_side) begin
                report_o.va_error = 1'b1;
                report_o.badv = sel.mem_addr;
            end
            // ADEF, ALE and ADEM are not tlb causes
            if ((fetch_side && cause_idx != `CAUSE_ADEF) || cause_idx >= `CAUSE_TLBR_M) begin
                report_o.excp_tlb = 1'b1;
                report_o.tlb_vppn = report_o.badv[`ADDR_W-1 -: 19];
            end
            report_o.tlbrefill = (cause_idx == `CAUSE_TLBR_F) || (cause_idx == `CAUSE_TLBR_M);
        end
    end

endmodule

`default_nettype wire

// File: commit_ctrl.sv
`include "commit_settings.svh"

`default_nettype none

module commit_ctrl
    import commit_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    lane_pair_if.dst                wb_i,
    input  wire logic               ex_branch_i,
    input  wire logic [1:0]         ex_stallreq_i,
    input  wire logic [1:0]         mem_stallreq_i,
    input  wire logic               dispatch_stallreq_i,
    input  wire logic               is_pri_instr_i,
    output logic [1:0]              rf_we_o,
    output logic [4:0]              rf_addr0_o,
    output logic [4:0]              rf_addr1_o,
    output logic [31:0]             rf_data0_o,
    output logic [31:0]             rf_data1_o,
    output logic                    excp_o,
    output excp_report_t            report_o,
    output logic [`ADDR_W-1:0]      era_o,
    output logic                    ertn_flush_o,
    output logic                    idle_flush_o,
    output logic                    flush_o,
    output logic [1:0]              ex_mem_flush_o,
    output logic [4:0]              stall_o,
    output logic                    pri_stall_o,
    output llbit_t                  llbit_o
);

    wb_lane_t           l0;
    wb_lane_t           l1;
    logic [`ADDR_W-1:0] excp_pc;
    logic               l0_idle;

    assign l0 = wb_i.lane[0];
    assign l1 = wb_i.lane[1];

    excp_encoder u_excp_encoder (
        .lane0_i   (l0),
        .lane1_i   (l1),
        .excp_o    (excp_o),
        .report_o  (report_o),
        .excp_pc_o (excp_pc)
    );

    // register file writes
    assign rf_we_o[0] = l0.valid && l0.rd_we && (l0.excp_num == '0);
    // lane 1 drops behind a group end or any exception
    assign rf_we_o[1] = l1.valid && l1.rd_we && (l1.excp_num == '0) &&
                        !(l0.valid && l0.ends_group) && !excp_o;
    assign rf_addr0_o = l0.rd;
    assign rf_addr1_o = l1.rd;
    assign rf_data0_o = l0.rd_data;
    assign rf_data1_o = l1.rd_data;

    assign l0_idle = l0.valid && (l0.op == OP_IDLE);
    assign ertn_flush_o = (l0.valid && l0.op == OP_ERTN) || (l1.valid && l1.op == OP_ERTN);
    assign idle_flush_o = l0_idle;
    assign flush_o = excp_o | ertn_flush_o;
    // a taken branch in lane 0 also kills lane 1
    assign ex_mem_flush_o = {flush_o | ex_branch_i, flush_o};
    // idle resumes at the next instruction
    assign era_o = l0_idle ? excp_pc + `ADDR_W'(4) : excp_pc;

    always_comb begin
        if (|ex_stallreq_i || |mem_stallreq_i) begin
            stall_o = 5'b11110;
        end else if (dispatch_stallreq_i) begin
            stall_o = 5'b11100;
        end else begin
            stall_o = 5'b00000;
        end
    end

    // privileged ops issue alone, so they commit in lane 0
    always_ff @(posedge clk) begin
        if (rst) begin
            pri_stall_o <= 1'b0;
        end else if (is_pri_instr_i) begin
            pri_stall_o <= 1'b1;
        end else if ((l0.valid && l0.is_priv) || excp_o) begin
            pri_stall_o <= 1'b0;
        end
    end

    assign llbit_o.we = l0.valid && (l0.op == OP_LL || l0.op == OP_SC) && !excp_o;
    assign llbit_o.value = l0.valid && (l0.op == OP_LL) && !excp_o;

endmodule

`default_nettype wire

// File: commit_unit_top.sv
`include "commit_settings.svh"

`default_nettype none

module commit_unit_top
    import commit_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  wire logic               lane0_valid_i,
    input  op_e                     lane0_op_i,
    input  wire logic [`ADDR_W-1:0] lane0_pc_i,
    input  wire logic [15:0]        lane0_excp_num_i,
    input  wire logic [`ADDR_W-1:0] lane0_mem_addr_i,
    input  wire logic [4:0]         lane0_rd_i,
    input  wire logic               lane0_rd_we_i,
    input  wire logic [31:0]        lane0_rd_data_i,
    input  wire logic               lane1_valid_i,
    input  op_e                     lane1_op_i,
    input  wire logic [`ADDR_W-1:0] lane1_pc_i,
    input  wire logic [15:0]        lane1_excp_num_i,
    input  wire logic [`ADDR_W-1:0] lane1_mem_addr_i,
    input  wire logic [4:0]         lane1_rd_i,
    input  wire logic               lane1_rd_we_i,
    input  wire logic [31:0]        lane1_rd_data_i,
    input  wire logic               ex_branch_i,
    input  wire logic [1:0]         ex_stallreq_i,
    input  wire logic [1:0]         mem_stallreq_i,
    input  wire logic               dispatch_stallreq_i,
    input  wire logic               is_pri_instr_i,
    output logic [1:0]              rf_we_o,
    output logic [4:0]              rf_addr0_o,
    output logic [4:0]              rf_addr1_o,
    output logic [31:0]             rf_data0_o,
    output logic [31:0]             rf_data1_o,
    output logic                    excp_o,
    output excp_report_t            report_o,
    output logic [`ADDR_W-1:0]      era_o,
    output logic                    ertn_flush_o,
    output logic                    idle_flush_o,
    output logic                    flush_o,
    output logic [1:0]              ex_mem_flush_o,
    output logic [4:0]              stall_o,
    output logic                    pri_stall_o,
    output llbit_t                  llbit_o
);

    logic [1:0] lane_kill;

    lane_pair_if dec_bus ();
    lane_pair_if wb_bus ();

    lane_decode u_lane_decode (
        .lane0_valid_i    (lane0_valid_i),
        .lane0_op_i       (lane0_op_i),
        .lane0_pc_i       (lane0_pc_i),
        .lane0_excp_num_i (lane0_excp_num_i),
        .lane0_mem_addr_i (lane0_mem_addr_i),
        .lane0_rd_i       (lane0_rd_i),
        .lane0_rd_we_i    (lane0_rd_we_i),
        .lane0_rd_data_i  (lane0_rd_data_i),
        .lane1_valid_i    (lane1_valid_i),
        .lane1_op_i       (lane1_op_i),
        .lane1_pc_i       (lane1_pc_i),
        .lane1_excp_num_i (lane1_excp_num_i),
        .lane1_mem_addr_i (lane1_mem_addr_i),
        .lane1_rd_i       (lane1_rd_i),
        .lane1_rd_we_i    (lane1_rd_we_i),
        .lane1_rd_data_i  (lane1_rd_data_i),
        .dec_o            (dec_bus.src)
    );

    // flush and branch kills feed back into the commit register
    wb_pipe_reg u_wb_pipe_reg (
        .clk         (clk),
        .rst         (rst),
        .dec_i       (dec_bus.dst),
        .lane_kill_i (lane_kill),
        .wb_o        (wb_bus.src)
    );

    commit_ctrl u_commit_ctrl (
        .clk                 (clk),
        .rst                 (rst),
        .wb_i                (wb_bus.dst),
        .ex_branch_i         (ex_branch_i),
        .ex_stallreq_i       (ex_stallreq_i),
        .mem_stallreq_i      (mem_stallreq_i),
        .dispatch_stallreq_i (dispatch_stallreq_i),
        .is_pri_instr_i      (is_pri_instr_i),
        .rf_we_o             (rf_we_o),
        .rf_addr0_o          (rf_addr0_o),
        .rf_addr1_o          (rf_addr1_o),
        .rf_data0_o          (rf_data0_o),
        .rf_data1_o          (rf_data1_o),
        .excp_o              (excp_o),
        .report_o            (report_o),
        .era_o               (era_o),
        .ertn_flush_o        (ertn_flush_o),
        .idle_flush_o        (idle_flush_o),
        .flush_o             (flush_o),
        .ex_mem_flush_o      (lane_kill),
        .stall_o             (stall_o),
        .pri_stall_o         (pri_stall_o),
        .llbit_o             (llbit_o)
    );

    assign ex_mem_flush_o = lane_kill;

endmodule

`default_nettype wire

// File: commit_checker.sv
`default_nettype none

module commit_checker (
    input wire logic       clk,
    input wire logic       rst,
    input wire logic [1:0] rf_we_i,
    input wire logic       excp_i,
    input wire logic       flush_i,
    input wire logic [1:0] ex_mem_flush_i,
    input wire logic [4:0] stall_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int failures = 0;

    // lane 1 is squashed behind any reported exception
    assert property (@(posedge clk) disable iff (rst) excp_i |-> !rf_we_i[1])
        else begin
            $error("lane 1 wrote back while an exception was reported");
            failures++;
        end

    // a commit flush kills both younger lanes
    assert property (@(posedge clk) disable iff (rst) flush_i |-> (ex_mem_flush_i == 2'b11))
        else begin
            $error("flush without both ex/mem kill bits");
            failures++;
        end

    assert property (@(posedge clk) disable iff (rst)
                     stall_i inside {5'b00000, 5'b11100, 5'b11110})
        else begin
            $error("stall vector outside the legal set");
            failures++;
        end

endmodule

`default_nettype wire

// File: tb_clock_gen.sv
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

    // synchronous reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_commit_monitor.sv
`include "commit_settings.svh"

`default_nettype none

module tb_commit_monitor
    import commit_pkg::*;
(
    input  wire logic               clk,
    input  wire logic               rst,
    input  int                      test_num_i,
    input  wb_lane_t                lane0_i,
    input  wb_lane_t                lane1_i,
    input  wire logic               ex_branch_i,
    input  wire logic [1:0]         ex_stallreq_i,
    input  wire logic [1:0]         mem_stallreq_i,
    input  wire logic               dispatch_stallreq_i,
    input  wire logic               is_pri_instr_i,
    input  wire logic [1:0]         rf_we_i,
    input  wire logic [4:0]         rf_addr0_i,
    input  wire logic [4:0]         rf_addr1_i,
    input  wire logic [31:0]        rf_data0_i,
    input  wire logic [31:0]        rf_data1_i,
    input  wire logic               excp_i,
    input  excp_report_t            report_i,
    input  wire logic [`ADDR_W-1:0] era_i,
    input  wire logic               ertn_flush_i,
    input  wire logic               idle_flush_i,
    input  wire logic               flush_i,
    input  wire logic [1:0]         ex_mem_flush_i,
    input  wire logic [4:0]         stall_i,
    input  wire logic               pri_stall_i,
    input  llbit_t                  llbit_i,
    output int                      mismatches_o,
    output int                      bad_tests_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // ecode per cause bit in priority order from bit 0
    localparam logic [5:0] ECODE_TAB [0:15] = '{
        `ECODE_INT, `ECODE_ADEF, `ECODE_TLBR, `ECODE_PIF,
        `ECODE_PPI, `ECODE_SYS, `ECODE_BRK, `ECODE_INE,
        `ECODE_IPE, `ECODE_ALE, `ECODE_ADEM, `ECODE_TLBR,
        `ECODE_PME, `ECODE_PPI, `ECODE_PIS, `ECODE_PIL
    };

    // model of the commit register
    wb_lane_t     m0;
    wb_lane_t     m1;
    logic         m_pri;
    logic         x_excp;
    logic         x_ertn;
    logic         x_idle;
    logic         x_flush;
    logic         x_ends;
    logic [1:0]   x_we;
    logic [1:0]   x_emf;
    logic [4:0]   x_stall;
    logic [31:0]  x_era;
    excp_report_t x_report;
    llbit_t       x_llbit;
    int           cur_test = 0;
    int           test_errs = 0;
    int           mismatches = 0;
    int           bad_tests = 0;

    assign mismatches_o = mismatches;
    assign bad_tests_o = bad_tests;

    function automatic logic privileged(input op_e op);
        return op inside {OP_CSRWR, OP_CSRRD, OP_SYSCALL, OP_BREAK,
                          OP_ERTN, OP_IDLE, OP_TLBSRCH};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            0: return "reset";
            1: return "writeback";
            2: return "exception";
            3: return "flush";
            4: return "stall";
            default: return "llsc";
        endcase
    endfunction

    function automatic excp_report_t expected_report(input wb_lane_t ln);
        excp_report_t r;
        int idx;
        r = '0;
        idx = 0;
        for (int i = 15; i >= 0; i--) begin
            if (ln.excp_num[i]) begin
                idx = i;
            end
        end
        r.ecode = ECODE_TAB[idx];
        if (idx == 1) begin
            r.esubcode = `ESUBCODE_ADEF;
        end
        if (idx == 10) begin
            r.esubcode = `ESUBCODE_ADEM;
        end
        // fetch causes report the pc, memory causes the data address
        if (idx >= 1 && idx <= 4) begin
            r.va_error = 1'b1;
            r.badv = ln.pc;
        end else if (idx >= 9) begin
            r.va_error = 1'b1;
            r.badv = ln.mem_addr;
        end
        if ((idx >= 2 && idx <= 4) || idx >= 11) begin
            r.excp_tlb = 1'b1;
            r.tlb_vppn = r.badv[31:13];
        end
        r.tlbrefill = (idx == 2) || (idx == 11);
        return r;
    endfunction

    always_comb begin
        logic e0;
        logic e1;
        wb_lane_t sel;
        e0 = m0.valid && (m0.excp_num != 16'h0);
        e1 = m1.valid && (m1.excp_num != 16'h0);
        x_excp = e0 || e1;
        sel = (!e0 && e1) ? m1 : m0;
        x_report = x_excp ? expected_report(sel) : '0;
        x_ends = m0.valid && (m0.op inside {OP_ERTN, OP_SYSCALL, OP_BREAK, OP_IDLE});
        x_we[0] = m0.valid && m0.rd_we && (m0.excp_num == 16'h0);
        x_we[1] = m1.valid && m1.rd_we && (m1.excp_num == 16'h0) && !x_ends && !x_excp;
        x_ertn = (m0.valid && m0.op == OP_ERTN) || (m1.valid && m1.op == OP_ERTN);
        x_idle = m0.valid && (m0.op == OP_IDLE);
        x_flush = x_excp || x_ertn;
        x_emf = {x_flush || ex_branch_i, x_flush};
        x_era = x_idle ? sel.pc + 32'd4 : sel.pc;
        if (ex_stallreq_i != 2'b00 || mem_stallreq_i != 2'b00) begin
            x_stall = 5'b11110;
        end else if (dispatch_stallreq_i) begin
            x_stall = 5'b11100;
        end else begin
            x_stall = 5'b00000;
        end
        x_llbit.we = m0.valid && (m0.op == OP_LL || m0.op == OP_SC) && !x_excp;
        x_llbit.value = m0.valid && (m0.op == OP_LL) && !x_excp;
    end

    // kill rule and pri_stall level
    always_ff @(posedge clk) begin
        if (rst) begin
            m0.valid <= 1'b0;
            m1.valid <= 1'b0;
            m_pri <= 1'b0;
        end else begin
            m0 <= lane0_i;
            m0.valid <= lane0_i.valid && !x_flush;
            m1 <= lane1_i;
            m1.valid <= lane1_i.valid && !(x_flush || ex_branch_i);
            if (is_pri_instr_i) begin
                m_pri <= 1'b1;
            end else if ((m0.valid && privileged(m0.op)) || x_excp) begin
                m_pri <= 1'b0;
            end
        end
    end

    task automatic compare(input string what, input logic [127:0] got,
                           input logic [127:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
            test_errs++;
            mismatches++;
        end
    endtask

    always @(negedge clk) begin
        if (test_num_i != cur_test) begin
            if (test_errs == 0) begin
                $display("test %0d %s: ok", cur_test, test_name(cur_test));
            end else begin
                $display("test %0d %s: %0d mismatches", cur_test, test_name(cur_test),
                         test_errs);
                bad_tests++;
            end
            cur_test = test_num_i;
            test_errs = 0;
        end
        if (!rst) begin
            compare("rf_we", rf_we_i, x_we);
            if (x_we[0]) begin
                compare("rf_addr0", rf_addr0_i, m0.rd);
                compare("rf_data0", rf_data0_i, m0.rd_data);
            end
            if (x_we[1]) begin
                compare("rf_addr1", rf_addr1_i, m1.rd);
                compare("rf_data1", rf_data1_i, m1.rd_data);
            end
            compare("excp", excp_i, x_excp);
            compare("report", report_i, x_report);
            if (x_excp || x_idle) begin
                compare("era", era_i, x_era);
            end
            compare("ertn_flush", ertn_flush_i, x_ertn);
            compare("idle_flush", idle_flush_i, x_idle);
            compare("flush", flush_i, x_flush);
            compare("ex_mem_flush", ex_mem_flush_i, x_emf);
            compare("stall", stall_i, x_stall);
            compare("pri_stall", pri_stall_i, m_pri);
            compare("llbit", llbit_i, x_llbit);
        end
    end

endmodule

`default_nettype wire

// File: tb_commit_unit.sv
`include "commit_settings.svh"

`default_nettype none

module tb_commit_unit
    import commit_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TESTS = 6;
    localparam int TEST_CYCLES = 400;
    localparam int RESET_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = TESTS * TEST_CYCLES + RESET_CYCLES + 100;

    logic               clk;
    logic               rst;
    wb_lane_t           stim0;
    wb_lane_t           stim1;
    logic               ex_branch;
    logic [1:0]         ex_stall;
    logic [1:0]         mem_stall;
    logic               disp_stall;
    logic               is_pri;
    logic [1:0]         rf_we;
    logic [4:0]         rf_addr0;
    logic [4:0]         rf_addr1;
    logic [31:0]        rf_data0;
    logic [31:0]        rf_data1;
    logic               excp;
    excp_report_t       report;
    logic [`ADDR_W-1:0] era;
    logic               ertn_flush;
    logic               idle_flush;
    logic               flush;
    logic [1:0]         ex_mem_flush;
    logic [4:0]         stall;
    logic               pri_stall;
    llbit_t             llbit;
    int                 test_num;
    int                 mismatches;
    int                 bad_tests;
    int                 cycles = 0;
    int                 seed = 18510;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .clk (clk),
        .rst (rst)
    );

    commit_unit_top dut_i (
        .clk (clk), .rst (rst),
        .lane0_valid_i (stim0.valid), .lane0_op_i (stim0.op), .lane0_pc_i (stim0.pc),
        .lane0_excp_num_i (stim0.excp_num), .lane0_mem_addr_i (stim0.mem_addr),
        .lane0_rd_i (stim0.rd), .lane0_rd_we_i (stim0.rd_we),
        .lane0_rd_data_i (stim0.rd_data),
        .lane1_valid_i (stim1.valid), .lane1_op_i (stim1.op), .lane1_pc_i (stim1.pc),
        .lane1_excp_num_i (stim1.excp_num), .lane1_mem_addr_i (stim1.mem_addr),
        .lane1_rd_i (stim1.rd), .lane1_rd_we_i (stim1.rd_we),
        .lane1_rd_data_i (stim1.rd_data),
        .ex_branch_i (ex_branch), .ex_stallreq_i (ex_stall), .mem_stallreq_i (mem_stall),
        .dispatch_stallreq_i (disp_stall), .is_pri_instr_i (is_pri),
        .rf_we_o (rf_we), .rf_addr0_o (rf_addr0), .rf_addr1_o (rf_addr1),
        .rf_data0_o (rf_data0), .rf_data1_o (rf_data1),
        .excp_o (excp), .report_o (report), .era_o (era),
        .ertn_flush_o (ertn_flush), .idle_flush_o (idle_flush), .flush_o (flush),
        .ex_mem_flush_o (ex_mem_flush), .stall_o (stall),
        .pri_stall_o (pri_stall), .llbit_o (llbit)
    );

    tb_commit_monitor u_monitor (
        .clk (clk), .rst (rst), .test_num_i (test_num),
        .lane0_i (stim0), .lane1_i (stim1), .ex_branch_i (ex_branch),
        .ex_stallreq_i (ex_stall), .mem_stallreq_i (mem_stall),
        .dispatch_stallreq_i (disp_stall), .is_pri_instr_i (is_pri),
        .rf_we_i (rf_we), .rf_addr0_i (rf_addr0), .rf_addr1_i (rf_addr1),
        .rf_data0_i (rf_data0), .rf_data1_i (rf_data1),
        .excp_i (excp), .report_i (report), .era_i (era),
        .ertn_flush_i (ertn_flush), .idle_flush_i (idle_flush), .flush_i (flush),
        .ex_mem_flush_i (ex_mem_flush), .stall_i (stall),
        .pri_stall_i (pri_stall), .llbit_i (llbit),
        .mismatches_o (mismatches), .bad_tests_o (bad_tests)
    );

    bind commit_ctrl commit_checker u_commit_checker (
        .clk            (clk),
        .rst            (rst),
        .rf_we_i        (rf_we_o),
        .excp_i         (excp_o),
        .flush_i        (flush_o),
        .ex_mem_flush_i (ex_mem_flush_o),
        .stall_i        (stall_o)
    );

    // one random lane biased by the running test
    task automatic draw_lane(input int t, output wb_lane_t ln);
        logic [31:0] r;
        r = $random(seed);
        ln = '0;
        ln.valid = (t == 0) ? (r[2:0] == 3'd0) : (r[2:0] != 3'd0);
        if (t == 5 && r[4:3] != 2'd0) begin
            ln.op = r[5] ? OP_LL : OP_SC;
        end else if (r[6:3] < ((t == 3) ? 4'd5 : 4'd11)) begin
            ln.op = OP_ALU;
        end else begin
            ln.op = op_e'(5'(r[10:7] % 4'd10 + 4'd1));
        end
        ln.pc = $random(seed);
        ln.mem_addr = $random(seed);
        ln.rd_data = $random(seed);
        r = $random(seed);
        ln.rd = r[4:0];
        ln.rd_we = r[5] | r[6];
        // exceptions mostly in the exception test
        if ((t == 2 && r[8:7] == 2'd0) || r[15:9] == 7'd0) begin
            ln.excp_num = (16'h1 << r[19:16]) | (r[20] ? (16'h1 << r[24:21]) : 16'h0);
        end
    endtask

    task automatic drive_cycle(input int t);
        wb_lane_t l0;
        wb_lane_t l1;
        logic [31:0] r;
        logic busy;
        draw_lane(t, l0);
        draw_lane(t, l1);
        r = $random(seed);
        busy = (t == 4);
        stim0 <= l0;
        stim1 <= l1;
        ex_branch <= (t == 1 || t == 3) && (r[2:0] == 3'd0);
        ex_stall <= (r[7:3] < (busy ? 5'd8 : 5'd1)) ? r[9:8] : 2'b00;
        mem_stall <= (r[14:10] < (busy ? 5'd8 : 5'd1)) ? r[16:15] : 2'b00;
        disp_stall <= r[21:17] < (busy ? 5'd8 : 5'd1);
        is_pri <= r[26:22] < (busy ? 5'd6 : 5'd1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        stim0 = '0;
        stim1 = '0;
        ex_branch = 1'b0;
        ex_stall = 2'b00;
        mem_stall = 2'b00;
        disp_stall = 1'b0;
        is_pri = 1'b0;
        test_num = 0;
        @(negedge rst);
        for (int t = 0; t < TESTS; t++) begin
            for (int c = 0; c < TEST_CYCLES; c++) begin
                @(posedge clk);
                if (c == 0) begin
                    test_num <= t;
                end
                drive_cycle(t);
            end
        end
        @(posedge clk);
        test_num <= TESTS;
        @(posedge clk);
        @(posedge clk);
        $display("summary: %0d tests run, %0d with mismatches, %0d mismatches in total",
                 TESTS, bad_tests, mismatches);
        if (mismatches == 0 && dut_i.u_commit_ctrl.u_commit_checker.failures == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: commit_unit_top.f
+incdir+.
commit_pkg.sv
lane_pair_if.sv
lane_decode.sv
wb_pipe_reg.sv
excp_encoder.sv
commit_ctrl.sv
commit_unit_top.sv
commit_checker.sv
tb_clock_gen.sv
tb_commit_monitor.sv
tb_commit_unit.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := tb_commit_unit
FILELIST  := commit_unit_top.f
OBJ_DIR   := obj_dir
PASS_MSG  := all tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
